// File: common/acc_cpu_pkg.sv
package acc_cpu_pkg;

    // machine widths
    localparam int word_width = 16;
    localparam int addr_width = 12;
    // one word per address, full 12-bit space
    localparam int mem_depth = 4096;

    // instruction set, top nibble of the word
    typedef enum logic [3:0] {
        op_lda = 4'h0,
        op_sta = 4'h1,
        op_add = 4'h2,
        op_sub = 4'h3,
        op_mul = 4'h4,
        op_and = 4'h5,
        op_or  = 4'h6,
        op_xor = 4'h7,
        op_shl = 4'h8,
        op_shr = 4'h9,
        op_rol = 4'ha,
        op_ror = 4'hb,
        op_ceq = 4'hc,
        op_jmp = 4'hd,
        op_jz  = 4'he,
        op_hlt = 4'hf
    } opcode_e;

    // alu operations, only the ones an instruction can reach
    typedef enum logic [3:0] {
        alu_add    = 4'h0,
        alu_sub    = 4'h1,
        alu_mul    = 4'h2,
        alu_and    = 4'h3,
        alu_or     = 4'h4,
        alu_xor    = 4'h5,
        alu_shl    = 4'h6,
        alu_shr    = 4'h7,
        alu_rol    = 4'h8,
        alu_ror    = 4'h9,
        alu_eq     = 4'ha,
        alu_pass_b = 4'hb
    } alu_op_e;

    // control sequencer states, one cycle each
    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_fetch     = 3'd1,
        st_fetch_rd  = 3'd2,
        st_decode    = 3'd3,
        st_exec_addr = 3'd4,
        st_exec_rd   = 3'd5,
        st_exec      = 3'd6,
        st_halted    = 3'd7
    } cpu_state_e;

    // memory word, seen as an instruction in IR or as an operand in MBR
    typedef union packed {
        struct packed {
            opcode_e               opcode;
            logic [addr_width-1:0] addr;
        } instr;
        logic [word_width-1:0] data;
    } instr_word_u;

endpackage

// File: common/mem_bus_if.sv
interface mem_bus_if;

    // address comes from MAR
    logic [acc_cpu_pkg::addr_width-1:0] addr;
    // store data is always the accumulator
    logic [acc_cpu_pkg::word_width-1:0] wdata;
    logic                               we;
    // registered read, word at last cycle's addr
    logic [acc_cpu_pkg::word_width-1:0] rdata;

    modport cpu (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport mem (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

// File: common/datapath_ctrl_if.sv
interface datapath_ctrl_if;

    // strobes from the FSM
    logic                 mar_load;
    // 0 takes PC, 1 takes IR address field
    logic                 mar_sel;
    logic                 ir_load;
    logic                 acc_load;
    logic                 store;
    acc_cpu_pkg::alu_op_e alu_op;

    // status back from the datapath
    acc_cpu_pkg::opcode_e opcode;
    logic                 acc_zero;

    modport fsm (
        output mar_load,
        output mar_sel,
        output ir_load,
        output acc_load,
        output store,
        output alu_op,
        input  opcode,
        input  acc_zero
    );

    modport dp (
        input  mar_load,
        input  mar_sel,
        input  ir_load,
        input  acc_load,
        input  store,
        input  alu_op,
        output opcode,
        output acc_zero
    );

endinterface

// File: datapath/alu.sv
module alu (
    input  acc_cpu_pkg::alu_op_e               op,
    input  logic [acc_cpu_pkg::word_width-1:0] a,
    input  logic [acc_cpu_pkg::word_width-1:0] b,
    output logic [acc_cpu_pkg::word_width-1:0] result
);

    localparam int msb = acc_cpu_pkg::word_width - 1;

    // all results truncated to the word width
    always_comb begin
        case (op)
            acc_cpu_pkg::alu_add: result = a + b;
            acc_cpu_pkg::alu_sub: result = a - b;
            // low half of the product
            acc_cpu_pkg::alu_mul: result = a * b;
            acc_cpu_pkg::alu_and: result = a & b;
            acc_cpu_pkg::alu_or:  result = a | b;
            acc_cpu_pkg::alu_xor: result = a ^ b;
            // single-bit moves of a, b unused
            acc_cpu_pkg::alu_shl: result = a << 1;
            acc_cpu_pkg::alu_shr: result = a >> 1;
            acc_cpu_pkg::alu_rol: result = {a[msb-1:0], a[msb]};
            acc_cpu_pkg::alu_ror: result = {a[0], a[msb:1]};
            // compare gives 1 or 0
            acc_cpu_pkg::alu_eq: begin
                result = '0;
                result[0] = (a == b);
            end
            // LDA path
            acc_cpu_pkg::alu_pass_b: result = b;
            default: result = '0;
        endcase
    end

endmodule

// File: datapath/datapath.sv
module datapath (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               start_clear,
    datapath_ctrl_if.dp                        ctrl,
    mem_bus_if.cpu                             bus,
    input  logic [acc_cpu_pkg::addr_width-1:0] pc,
    output logic [acc_cpu_pkg::addr_width-1:0] ir_addr,
    output logic [acc_cpu_pkg::word_width-1:0] acc
);

    logic [acc_cpu_pkg::addr_width-1:0] mar;
    acc_cpu_pkg::instr_word_u           ir;
    // MBR is the registered memory output itself
    acc_cpu_pkg::instr_word_u           mbr;
    logic [acc_cpu_pkg::word_width-1:0] alu_result;

    assign mbr = bus.rdata;

    // MAR, source is PC on fetch, IR address on execute
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (ctrl.mar_load) begin
            mar <= ctrl.mar_sel ? ir.instr.addr : pc;
        end
    end

    // IR, fetched word seen as opcode and address
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ctrl.ir_load) begin
            ir <= mbr;
        end
    end

    // accumulator
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (start_clear) begin
            acc <= '0;
        end else if (ctrl.acc_load) begin
            acc <= alu_result;
        end
    end

    // operand b is the memory word as plain data
    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (acc),
        .b      (mbr.data),
        .result (alu_result)
    );

    // status to the FSM
    assign ctrl.opcode   = ir.instr.opcode;
    assign ctrl.acc_zero = (acc == '0);
    assign ir_addr       = ir.instr.addr;

    // memory port, store data is always the accumulator
    assign bus.addr  = mar;
    assign bus.wdata = acc;
    assign bus.we    = ctrl.store;

endmodule

// File: src/pc_counter.sv
module pc_counter (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               start_clear,
    input  logic                               pc_inc,
    input  logic                               pc_load,
    input  logic [acc_cpu_pkg::addr_width-1:0] jump_addr,
    output logic [acc_cpu_pkg::addr_width-1:0] pc
);

    // priority: restart, then jump, then step
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (start_clear) begin
            pc <= '0;
        end else if (pc_load) begin
            // jump target from IR address field
            pc <= jump_addr;
        end else if (pc_inc) begin
            // 4095 rolls over to 0 at full width
            pc <= pc + 1'b1;
        end
    end

endmodule

// File: src/main_memory.sv
module main_memory (
    input  logic                               clock,
    mem_bus_if.mem                             bus,
    input  logic                               load_en,
    input  logic [acc_cpu_pkg::addr_width-1:0] load_addr,
    input  logic [acc_cpu_pkg::word_width-1:0] load_data
);

    // word array, no reset
    logic [acc_cpu_pkg::word_width-1:0] mem [acc_cpu_pkg::mem_depth];

    // writes, load port wins over the cpu
    // load port only used while the cpu is stopped
    always_ff @(posedge clock) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (bus.we) begin
            mem[bus.addr] <= bus.wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clock) begin
        bus.rdata <= mem[bus.addr];
    end

endmodule

// File: control/control_fsm.sv
module control_fsm (
    input  logic         clock,
    input  logic         rst_n,
    input  logic         run,
    datapath_ctrl_if.fsm ctrl,
    output logic         pc_inc,
    output logic         pc_load,
    output logic         start_clear,
    output logic         halted
);

    acc_cpu_pkg::cpu_state_e state;
    acc_cpu_pkg::cpu_state_e state_next;
    // instruction classes decoded from IR
    logic                    mem_operand;
    logic                    shift_op;

    // classify current opcode
    // only looked at from exec_addr on, when IR is valid
    always_comb begin
        mem_operand = 1'b0;
        shift_op    = 1'b0;
        case (ctrl.opcode)
            acc_cpu_pkg::op_lda,
            acc_cpu_pkg::op_add,
            acc_cpu_pkg::op_sub,
            acc_cpu_pkg::op_mul,
            acc_cpu_pkg::op_and,
            acc_cpu_pkg::op_or,
            acc_cpu_pkg::op_xor,
            acc_cpu_pkg::op_ceq: mem_operand = 1'b1;
            acc_cpu_pkg::op_shl,
            acc_cpu_pkg::op_shr,
            acc_cpu_pkg::op_rol,
            acc_cpu_pkg::op_ror: shift_op = 1'b1;
            default: mem_operand = 1'b0;
        endcase
    end

    // opcode to alu operation
    // LDA goes through the alu as pass_b
    always_comb begin
        case (ctrl.opcode)
            acc_cpu_pkg::op_add: ctrl.alu_op = acc_cpu_pkg::alu_add;
            acc_cpu_pkg::op_sub: ctrl.alu_op = acc_cpu_pkg::alu_sub;
            acc_cpu_pkg::op_mul: ctrl.alu_op = acc_cpu_pkg::alu_mul;
            acc_cpu_pkg::op_and: ctrl.alu_op = acc_cpu_pkg::alu_and;
            acc_cpu_pkg::op_or:  ctrl.alu_op = acc_cpu_pkg::alu_or;
            acc_cpu_pkg::op_xor: ctrl.alu_op = acc_cpu_pkg::alu_xor;
            acc_cpu_pkg::op_shl: ctrl.alu_op = acc_cpu_pkg::alu_shl;
            acc_cpu_pkg::op_shr: ctrl.alu_op = acc_cpu_pkg::alu_shr;
            acc_cpu_pkg::op_rol: ctrl.alu_op = acc_cpu_pkg::alu_rol;
            acc_cpu_pkg::op_ror: ctrl.alu_op = acc_cpu_pkg::alu_ror;
            acc_cpu_pkg::op_ceq: ctrl.alu_op = acc_cpu_pkg::alu_eq;
            default:             ctrl.alu_op = acc_cpu_pkg::alu_pass_b;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= acc_cpu_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    // next state and strobes, all strobes default low
    always_comb begin
        state_next    = state;
        ctrl.mar_load = 1'b0;
        ctrl.mar_sel  = 1'b0;
        ctrl.ir_load  = 1'b0;
        ctrl.acc_load = 1'b0;
        ctrl.store    = 1'b0;
        pc_inc        = 1'b0;
        pc_load       = 1'b0;
        start_clear   = 1'b0;
        case (state)
            // run restarts from address 0 with a clean accumulator
            acc_cpu_pkg::st_idle,
            acc_cpu_pkg::st_halted: begin
                if (run) begin
                    start_clear = 1'b1;
                    state_next  = acc_cpu_pkg::st_fetch;
                end
            end
            acc_cpu_pkg::st_fetch: begin
                ctrl.mar_load = 1'b1;
                state_next    = acc_cpu_pkg::st_fetch_rd;
            end
            // memory read latency
            acc_cpu_pkg::st_fetch_rd: state_next = acc_cpu_pkg::st_decode;
            acc_cpu_pkg::st_decode: begin
                ctrl.ir_load = 1'b1;
                pc_inc       = 1'b1;
                state_next   = acc_cpu_pkg::st_exec_addr;
            end
            acc_cpu_pkg::st_exec_addr: begin
                if (mem_operand) begin
                    ctrl.mar_load = 1'b1;
                    ctrl.mar_sel  = 1'b1;
                    state_next    = acc_cpu_pkg::st_exec_rd;
                end else if (shift_op) begin
                    // shifts finish here, acc only
                    ctrl.acc_load = 1'b1;
                    state_next    = acc_cpu_pkg::st_fetch;
                end else if (ctrl.opcode == acc_cpu_pkg::op_sta) begin
                    // no read needed, straight to the write
                    ctrl.mar_load = 1'b1;
                    ctrl.mar_sel  = 1'b1;
                    state_next    = acc_cpu_pkg::st_exec;
                end else if (ctrl.opcode == acc_cpu_pkg::op_jmp) begin
                    pc_load    = 1'b1;
                    state_next = acc_cpu_pkg::st_fetch;
                end else if (ctrl.opcode == acc_cpu_pkg::op_jz) begin
                    // untaken JZ just falls through
                    pc_load    = ctrl.acc_zero;
                    state_next = acc_cpu_pkg::st_fetch;
                end else begin
                    state_next = acc_cpu_pkg::st_halted;
                end
            end
            acc_cpu_pkg::st_exec_rd: state_next = acc_cpu_pkg::st_exec;
            acc_cpu_pkg::st_exec: begin
                if (ctrl.opcode == acc_cpu_pkg::op_sta) begin
                    ctrl.store = 1'b1;
                end else begin
                    ctrl.acc_load = 1'b1;
                end
                state_next = acc_cpu_pkg::st_fetch;
            end
            default: state_next = acc_cpu_pkg::st_idle;
        endcase
    end

    assign halted = (state == acc_cpu_pkg::st_halted);

endmodule

// File: src/accumulator_cpu.sv
module accumulator_cpu (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               run,
    input  logic                               load_en,
    input  logic [acc_cpu_pkg::addr_width-1:0] load_addr,
    input  logic [acc_cpu_pkg::word_width-1:0] load_data,
    output logic                               halted,
    output logic [acc_cpu_pkg::word_width-1:0] acc_out,
    output logic [acc_cpu_pkg::addr_width-1:0] pc_out
);

    // FSM to PC and restart
    logic                               pc_inc;
    logic                               pc_load;
    logic                               start_clear;
    // jump target out of IR
    logic [acc_cpu_pkg::addr_width-1:0] ir_addr;

    datapath_ctrl_if u_ctrl_if ();
    mem_bus_if       u_mem_bus ();

    control_fsm u_control_fsm (
        .clock       (clock),
        .rst_n       (rst_n),
        .run         (run),
        .ctrl        (u_ctrl_if.fsm),
        .pc_inc      (pc_inc),
        .pc_load     (pc_load),
        .start_clear (start_clear),
        .halted      (halted)
    );

    pc_counter u_pc_counter (
        .clock       (clock),
        .rst_n       (rst_n),
        .start_clear (start_clear),
        .pc_inc      (pc_inc),
        .pc_load     (pc_load),
        .jump_addr   (ir_addr),
        .pc          (pc_out)
    );

    datapath u_datapath (
        .clock       (clock),
        .rst_n       (rst_n),
        .start_clear (start_clear),
        .ctrl        (u_ctrl_if.dp),
        .bus         (u_mem_bus.cpu),
        .pc          (pc_out),
        .ir_addr     (ir_addr),
        .acc         (acc_out)
    );

    main_memory u_main_memory (
        .clock     (clock),
        .bus       (u_mem_bus.mem),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// File: testbench/cpu_asserts.sv
module cpu_asserts (
    input logic                    clock,
    input logic                    rst_n,
    input acc_cpu_pkg::cpu_state_e state,
    input acc_cpu_pkg::opcode_e    opcode,
    input logic                    mar_load,
    input logic                    ir_load,
    input logic                    acc_load,
    input logic                    store,
    input logic                    pc_inc,
    input logic                    pc_load,
    input logic                    halted
);

    // memory write strobe only in the execute cycle
    store_only_in_exec: assert property (@(posedge clock) disable iff (!rst_n)
        store |-> state == acc_cpu_pkg::st_exec)
        else $error("store strobe seen outside the EXEC state");

    // jump and step on the PC are exclusive
    pc_load_inc_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
        !(pc_load && pc_inc))
        else $error("pc_load and pc_inc high in the same cycle");

    // halted only ever entered from a decoded HLT
    halt_entered_from_hlt: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(halted) |-> $past(state) == acc_cpu_pkg::st_exec_addr
            && $past(opcode) == acc_cpu_pkg::op_hlt)
        else $error("halted rose without an HLT in the EXEC_ADDR state");

    // nothing moves while idle
    idle_strobes_low: assert property (@(posedge clock) disable iff (!rst_n)
        state == acc_cpu_pkg::st_idle
            |-> !(mar_load || ir_load || acc_load || store || pc_inc || pc_load))
        else $error("datapath strobe high in the IDLE state");

endmodule

bind control_fsm cpu_asserts u_cpu_asserts (
    .clock    (clock),
    .rst_n    (rst_n),
    .state    (state),
    .opcode   (ctrl.opcode),
    .mar_load (ctrl.mar_load),
    .ir_load  (ctrl.ir_load),
    .acc_load (ctrl.acc_load),
    .store    (ctrl.store),
    .pc_inc   (pc_inc),
    .pc_load  (pc_load),
    .halted   (halted)
);

// File: testbench/tb_accumulator_cpu.sv
module tb_accumulator_cpu;

    localparam int          max_cycles = 2000;
    localparam logic [31:0] lfsr_seed  = 32'hca100610;
    // right-shift galois taps, x^32 + x^31 + x^29 + x + 1
    localparam logic [31:0] lfsr_taps  = 32'hd0000001;

    logic        clock;
    logic        rst_n;
    logic        run;
    logic        load_en;
    logic [11:0] load_addr;
    logic [15:0] load_data;
    logic        halted;
    logic [15:0] acc_out;
    logic [11:0] pc_out;

    logic [31:0] lfsr_state;
    // program image, loaded from address 0
    logic [15:0] prog [$];

    accumulator_cpu u_accumulator_cpu (
        .clock     (clock),
        .rst_n     (rst_n),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .halted    (halted),
        .acc_out   (acc_out),
        .pc_out    (pc_out)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // one lfsr step per bit handed out
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ lfsr_taps;
        end
        return out_bit;
    endfunction

    function automatic logic [15:0] random_word();
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            w = {w[14:0], next_random_bit()};
        end
        return w;
    endfunction

    // opcode in the top nibble, address below
    function automatic logic [15:0] encode(acc_cpu_pkg::opcode_e op, logic [11:0] addr);
        return {op, addr};
    endfunction

    // 3 fetch cycles plus the execute part
    function automatic int instr_cycles(logic [15:0] word);
        case (acc_cpu_pkg::opcode_e'(word[15:12]))
            acc_cpu_pkg::op_sta: return 5;
            acc_cpu_pkg::op_shl,
            acc_cpu_pkg::op_shr,
            acc_cpu_pkg::op_rol,
            acc_cpu_pkg::op_ror,
            acc_cpu_pkg::op_jmp,
            acc_cpu_pkg::op_jz,
            acc_cpu_pkg::op_hlt: return 4;
            default: return 6;
        endcase
    endfunction

    // only valid for programs without a taken jump
    function automatic int straight_line_cycles();
        int total;
        total = 0;
        foreach (prog[i]) begin
            total += instr_cycles(prog[i]);
        end
        return total;
    endfunction

    // reference model, acc is a and the memory word is b
    function automatic logic [15:0] expected_result(acc_cpu_pkg::opcode_e op,
                                                    logic [15:0] a, logic [15:0] b);
        logic [31:0] product;
        case (op)
            acc_cpu_pkg::op_add: return a + b;
            acc_cpu_pkg::op_sub: return a - b;
            acc_cpu_pkg::op_mul: begin
                product = 32'(a) * 32'(b);
                return product[15:0];
            end
            acc_cpu_pkg::op_and: return a & b;
            acc_cpu_pkg::op_or:  return a | b;
            acc_cpu_pkg::op_xor: return a ^ b;
            acc_cpu_pkg::op_shl: return {a[14:0], 1'b0};
            acc_cpu_pkg::op_shr: return {1'b0, a[15:1]};
            acc_cpu_pkg::op_rol: return {a[14:0], a[15]};
            acc_cpu_pkg::op_ror: return {a[0], a[15:1]};
            acc_cpu_pkg::op_ceq: return (a == b) ? 16'd1 : 16'd0;
            default: return b;
        endcase
    endfunction

    task automatic check(input string name, input logic [15:0] got,
                         input logic [15:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // one word through the load port
    task automatic write_word(input logic [11:0] addr, input logic [15:0] data);
        @(posedge clock);
        load_en   <= 1'b1;
        load_addr <= addr;
        load_data <= data;
        @(posedge clock);
        load_en   <= 1'b0;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            write_word(12'(i), prog[i]);
        end
    endtask

    // cycles counted from the edge that samples run
    task automatic run_program(output int cycles);
        cycles = 0;
        @(posedge clock);
        run <= 1'b1;
        @(posedge clock);
        run <= 1'b0;
        // halted looked at mid-cycle
        @(negedge clock);
        while (!halted) begin
            @(negedge clock);
            cycles++;
            if (cycles > max_cycles) begin
                $display("timeout, the machine did not halt within %0d cycles", max_cycles);
                $display("Errors found");
                $fatal(1);
            end
        end
    endtask

    task automatic test_reset_state();
        @(negedge clock);
        check("halted", 16'(halted), 16'h0);
        check("acc_out", acc_out, 16'h0);
        check("pc_out", 16'(pc_out), 16'h0);
    endtask

    // stored sum read back through memory
    task automatic test_store_round_trip();
        logic [15:0] x;
        logic [15:0] y;
        int          cycles;
        x = random_word();
        y = random_word();
        write_word(12'h100, x);
        write_word(12'h101, y);
        // stale value, must be overwritten by STA
        write_word(12'h102, ~(x + y));
        prog.delete();
        prog.push_back(encode(acc_cpu_pkg::op_lda, 12'h100));
        prog.push_back(encode(acc_cpu_pkg::op_add, 12'h101));
        prog.push_back(encode(acc_cpu_pkg::op_sta, 12'h102));
        prog.push_back(encode(acc_cpu_pkg::op_lda, 12'h102));
        prog.push_back(encode(acc_cpu_pkg::op_hlt, 12'h000));
        load_program();
        run_program(cycles);
        check("acc_out", acc_out, expected_result(acc_cpu_pkg::op_add, x, y));
        check("pc_out", 16'(pc_out), 16'h5);
        check("run to halted cycles", 16'(cycles), 16'(straight_line_cycles()));
    endtask

    task automatic test_alu_op(input acc_cpu_pkg::opcode_e op, input logic equal_operands);
        logic [15:0] x;
        logic [15:0] y;
        int          cycles;
        x = random_word();
        y = x;
        if (!equal_operands) begin
            y = random_word();
        end
        write_word(12'h110, x);
        write_word(12'h111, y);
        prog.delete();
        prog.push_back(encode(acc_cpu_pkg::op_lda, 12'h110));
        prog.push_back(encode(op, 12'h111));
        prog.push_back(encode(acc_cpu_pkg::op_hlt, 12'h000));
        load_program();
        run_program(cycles);
        check($sformatf("acc_out after %s", op.name()), acc_out, expected_result(op, x, y));
        check("run to halted cycles", 16'(cycles), 16'(straight_line_cycles()));
    endtask

    // address field is junk, shifts must ignore it
    task automatic test_shift(input acc_cpu_pkg::opcode_e op);
        logic [15:0] x;
        int          cycles;
        x = random_word();
        write_word(12'h120, x);
        prog.delete();
        prog.push_back(encode(acc_cpu_pkg::op_lda, 12'h120));
        prog.push_back(encode(op, 12'habc));
        prog.push_back(encode(acc_cpu_pkg::op_hlt, 12'h000));
        load_program();
        run_program(cycles);
        check($sformatf("acc_out after %s", op.name()), acc_out,
              expected_result(op, x, 16'h0));
        check("run to halted cycles", 16'(cycles), 16'(straight_line_cycles()));
    endtask

    // branch to 3 skips the HLT at 2
    task automatic test_branch(input acc_cpu_pkg::opcode_e op, input logic [15:0] first,
                               input logic [15:0] second);
        logic taken;
        int   cycles;
        taken = (op == acc_cpu_pkg::op_jmp) || (first == 16'h0);
        write_word(12'h130, first);
        write_word(12'h131, second);
        prog.delete();
        prog.push_back(encode(acc_cpu_pkg::op_lda, 12'h130));
        prog.push_back(encode(op, 12'h003));
        prog.push_back(encode(acc_cpu_pkg::op_hlt, 12'h000));
        prog.push_back(encode(acc_cpu_pkg::op_lda, 12'h131));
        prog.push_back(encode(acc_cpu_pkg::op_hlt, 12'h000));
        load_program();
        run_program(cycles);
        check($sformatf("acc_out after %s", op.name()), acc_out, taken ? second : first);
        // HLT address plus one
        check($sformatf("pc_out after %s", op.name()), 16'(pc_out), taken ? 16'h5 : 16'h3);
    endtask

    initial begin
        logic [15:0] first;
        logic [15:0] second;
        rst_n      = 1'b0;
        run        = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        lfsr_state = lfsr_seed;
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;

        test_reset_state();
        test_store_round_trip();

        test_alu_op(acc_cpu_pkg::op_add, 1'b0);
        test_alu_op(acc_cpu_pkg::op_sub, 1'b0);
        test_alu_op(acc_cpu_pkg::op_mul, 1'b0);
        test_alu_op(acc_cpu_pkg::op_and, 1'b0);
        test_alu_op(acc_cpu_pkg::op_or, 1'b0);
        test_alu_op(acc_cpu_pkg::op_xor, 1'b0);
        test_alu_op(acc_cpu_pkg::op_ceq, 1'b0);
        test_alu_op(acc_cpu_pkg::op_ceq, 1'b1);

        test_shift(acc_cpu_pkg::op_shl);
        test_shift(acc_cpu_pkg::op_shr);
        test_shift(acc_cpu_pkg::op_rol);
        test_shift(acc_cpu_pkg::op_ror);

        first  = random_word();
        second = random_word();
        test_branch(acc_cpu_pkg::op_jmp, first, second);
        // zero accumulator, JZ taken
        second = random_word() | 16'h1;
        test_branch(acc_cpu_pkg::op_jz, 16'h0, second);
        // nonzero accumulator falls through
        first  = random_word() | 16'h1;
        second = random_word();
        test_branch(acc_cpu_pkg::op_jz, first, second);

        $display("No errors");
        $finish;
    end

endmodule

// File: filelist.f
common/acc_cpu_pkg.sv
common/mem_bus_if.sv
common/datapath_ctrl_if.sv
datapath/alu.sv
datapath/datapath.sv
src/pc_counter.sv
src/main_memory.sv
control/control_fsm.sv
src/accumulator_cpu.sv
testbench/cpu_asserts.sv
testbench/tb_accumulator_cpu.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_accumulator_cpu \
		-f filelist.f -Mdir obj_dir
	./obj_dir/Vtb_accumulator_cpu | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
